//--- rvPipe.f
+incdir+hdl
hdl/rvIsaPkg.sv
hdl/rvPipePkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/aluUnit.sv
hdl/executeStage.sv
hdl/rvPipe.sv
verif/clockGen.sv
verif/rvPipe_properties.sv
verif/rvPipe_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the rvPipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rvPipe.f --top-module rvPipe_tb \
    -Mdir obj_dir -o rvPipe_sim

./obj_dir/rvPipe_sim > sim.log 2>&1 || echo "Simulator exited with a failing status" >> sim.log
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

//--- verif/rvPipe_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_settings.svh"

module rvPipe_tb import rvIsaPkg::*; ();

    localparam int memWords = 1024;
    localparam int randCount = 200;  // Random instructions after the register prologue
    localparam int waitLimit = 5000;
    localparam logic [31:0] nopWord = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [6:0] opcodeLoad = 7'b0000011;   // Unsupported opcode that retires as a bubble

    logic                     clk;
    logic                     rstN;
    logic [`RV_XLEN-1:0]      imemData = nopWord;
    logic [`RV_XLEN-1:0]      imemAddr;
    logic                     wbValid;
    logic [`RV_REG_IDX_W-1:0] wbRd;
    logic [`RV_XLEN-1:0]      wbData;
    logic [`RV_XLEN-1:0]      nextFetch;

    logic [31:0] imem [0:memWords-1];
    logic [31:0] model [0:31];       // Architectural state seen by the reference
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    logic [4:0]  rdExp;
    logic [31:0] dataExp;
    logic [31:0] lfsrState;
    logic [4:0]  prevRd;             // Destination of the last emitted instruction
    int progLen;
    int errorCount;
    int timeoutCount;
    int wbCount;
    int expectedCount;
    int cyclesOut;                   // Cycles since reset release
    int waitCycles;

    clockGen clocks (
        .clk  (clk),
        .rstN (rstN)
    );

    rvPipe UUT (
        .clk      (clk),
        .rstN     (rstN),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .wbValid  (wbValid),
        .wbRd     (wbRd),
        .wbData   (wbData)
    );

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);  // One step per bit
            v = {v[30:0], lfsrState[31]};
        end
    endtask

    // RV32I result of one kept instruction from the rs1 and rs2 values a and b
    function automatic logic [31:0] refValue(input instrWord ins, input logic [31:0] pc,
                                             input logic [31:0] a, input logic [31:0] b);
        logic [31:0] immI;
        logic [31:0] immU;
        logic [31:0] opB;
        logic        alt;
        immI = {{20{ins.iType.imm12[11]}}, ins.iType.imm12};
        immU = {ins.uType.imm20, 12'h000};
        alt  = ins.rType.funct7[5];  // Instruction bit 30
        opB  = (ins.rType.opcode == opcodeOp) ? b : immI;
        if (ins.rType.opcode == opcodeLui) begin
            return immU;
        end
        if (ins.rType.opcode == opcodeAuipc) begin
            return pc + immU;
        end
        case (ins.rType.funct3)
            f3AddSub: return (ins.rType.opcode == opcodeOp && alt) ? a - opB : a + opB;
            f3Sll:    return a << opB[4:0];
            f3Slt:    return ($signed(a) < $signed(opB)) ? 32'd1 : 32'd0;
            f3Sltu:   return (a < opB) ? 32'd1 : 32'd0;
            f3Xor:    return a ^ opB;
            f3SrlSra: return alt ? $unsigned($signed(a) >>> opB[4:0]) : a >> opB[4:0];
            f3Or:     return a | opB;
            default:  return a & opB;
        endcase
    endfunction

    // Place one word in memory and run it on the model
    task automatic emit(input instrWord ins);
        logic [31:0] pc;
        logic [31:0] value;
        logic        known;
        pc = 32'(progLen) << 2;
        imem[progLen] = ins;
        known = (ins.rType.opcode == opcodeOp) || (ins.rType.opcode == opcodeOpImm) ||
                (ins.rType.opcode == opcodeLui) || (ins.rType.opcode == opcodeAuipc);
        if (known && ins.rType.rd != 5'd0) begin
            value = refValue(ins, pc, model[ins.rType.rs1], model[ins.rType.rs2]);
            model[ins.rType.rd] = value;
            expRd.push_back(ins.rType.rd);
            expData.push_back(value);
            prevRd = ins.rType.rd;
        end else begin
            prevRd = 5'd0;  // Nothing to forward from
        end
        progLen++;
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        logic [2:0]  cls;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [19:0] upper;
        logic        usesRs1;
        logic        usesRs2;
        instrWord    ins;
        // Prologue gives every register a known random upper value
        for (int i = 1; i < 32; i++) begin
            takeBits(20, r);
            ins = '0;
            ins.uType.imm20  = r[19:0];
            ins.uType.rd     = 5'(i);
            ins.uType.opcode = opcodeLui;
            emit(ins);
        end
        for (int n = 0; n < randCount; n++) begin
            takeBits(3, r);
            cls = r[2:0];
            takeBits(5, r);
            rd = r[4:0];
            takeBits(5, r);
            rs1 = r[4:0];
            takeBits(5, r);
            rs2 = r[4:0];
            takeBits(3, r);
            f3 = r[2:0];
            takeBits(1, r);
            alt = r[0];
            takeBits(12, r);
            imm = r[11:0];
            takeBits(20, r);
            upper = r[19:0];
            ins = '0;
            usesRs1 = 1'b0;
            usesRs2 = 1'b0;
            if (cls <= 3'd2) begin  // R-type
                ins.rType.funct7 = (alt && (f3 == f3AddSub || f3 == f3SrlSra)) ?
                                   7'b0100000 : 7'b0000000;
                ins.rType.rs2    = rs2;
                ins.rType.rs1    = rs1;
                ins.rType.funct3 = f3;
                ins.rType.rd     = rd;
                ins.rType.opcode = opcodeOp;
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
            end else if (cls <= 3'd4) begin  // I-type
                if (f3 == f3Sll) begin
                    imm = {7'b0000000, imm[4:0]};
                end else if (f3 == f3SrlSra) begin
                    imm = {1'b0, alt, 5'b00000, imm[4:0]};  // srai or srli
                end
                ins.iType.imm12  = imm;
                ins.iType.rs1    = rs1;
                ins.iType.funct3 = f3;
                ins.iType.rd     = rd;
                ins.iType.opcode = opcodeOpImm;
                usesRs1 = 1'b1;
            end else begin
                ins.uType.imm20 = upper;
                ins.uType.rd    = rd;
                if (cls == 3'd5) begin
                    ins.uType.opcode = opcodeLui;
                end else if (cls == 3'd6) begin
                    ins.uType.opcode = opcodeAuipc;
                end else begin
                    ins.uType.opcode = opcodeLoad;
                end
            end
            // One-slot hazard is not handled by the core
            if (prevRd != 5'd0 &&
                ((usesRs1 && rs1 == prevRd) || (usesRs2 && rs2 == prevRd))) begin
                emit(instrWord'(nopWord));
            end
            emit(ins);
        end
    endtask

    // Memory model fetches from the address the PC will hold after this edge
    assign nextFetch = rstN ? imemAddr + `RV_PC_STEP : `RV_RESET_PC;

    always @(posedge clk) begin
        imemData <= imem[nextFetch[11:2]];
    end

    // Compare process samples mid-cycle
    always @(negedge clk) begin
        if (!rstN) begin
            assert (wbValid == 1'b0) else begin
                errorCount++;
                $display("CHECK FAILED at %0t: wbValid high during reset", $time);
            end
            cyclesOut = 0;
        end else begin
            assert (imemAddr == (32'(cyclesOut) << 2)) else begin
                errorCount++;
                $display("CHECK FAILED at %0t: imemAddr %h, expected %h", $time, imemAddr,
                         32'(cyclesOut) << 2);
            end
            if (cyclesOut < 3) begin  // Pipeline still filling
                assert (wbValid == 1'b0) else begin
                    errorCount++;
                    $display("CHECK FAILED at %0t: wbValid high %0d cycles after reset",
                             $time, cyclesOut);
                end
            end
            if (wbValid) begin
                wbCount++;
                assert (expRd.size() != 0) else begin
                    errorCount++;
                    $display("Unexpected write-back to x%0d at %0t, no write was expected",
                             wbRd, $time);
                end
                if (expRd.size() != 0) begin
                    rdExp   = expRd.pop_front();
                    dataExp = expData.pop_front();
                    assert (wbRd == rdExp && wbData == dataExp) else begin
                        errorCount++;
                        $display("CHECK FAILED at %0t: write %0d is x%0d = %h, expected x%0d = %h",
                                 $time, wbCount, wbRd, wbData, rdExp, dataExp);
                    end
                end
            end
            cyclesOut++;
        end
    end

    initial begin
        errorCount   = 0;
        timeoutCount = 0;
        wbCount      = 0;
        cyclesOut    = 0;
        progLen      = 0;
        prevRd       = 5'd0;
        lfsrState    = 32'd72179;
        for (int i = 0; i < memWords; i++) begin
            imem[i] = nopWord;  // Past the program
        end
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'd0;
        end
        buildProgram();
        expectedCount = expRd.size();

        waitCycles = 0;
        while (rstN !== 1'b1 && waitCycles < waitLimit) begin
            @(posedge clk);
            waitCycles++;
        end
        if (rstN !== 1'b1) begin
            timeoutCount++;
            $display("Timed out waiting for reset to be released");
        end

        waitCycles = 0;
        while (wbCount < expectedCount && waitCycles < waitLimit) begin
            @(posedge clk);
            waitCycles++;
        end
        if (wbCount < expectedCount) begin
            timeoutCount++;
            $display("Timed out waiting for write-backs, saw %0d of %0d", wbCount, expectedCount);
        end

        // Let fetch run past the program so late or extra writes show up
        waitCycles = 0;
        while (imemAddr < (32'(progLen + 8) << 2) && waitCycles < waitLimit) begin
            @(posedge clk);
            waitCycles++;
        end
        if (imemAddr < (32'(progLen + 8) << 2)) begin
            timeoutCount++;
            $display("Timed out waiting for fetch to pass the end of the program");
        end

        assert (wbCount == expectedCount && expRd.size() == 0) else begin
            errorCount++;
            $display("CHECK FAILED at %0t: %0d write-backs, expected %0d, %0d left in queue",
                     $time, wbCount, expectedCount, expRd.size());
        end

        $display("Error counts: %0d check failures, %0d timeouts (%0d of %0d writes seen)",
                 errorCount, timeoutCount, wbCount, expectedCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/rvPipe_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_settings.svh"

module rvPipe_properties (
    input logic                     clk,
    input logic                     rstN,
    input logic [`RV_XLEN-1:0]      imemAddr,
    input logic                     wbValid,
    input logic [`RV_REG_IDX_W-1:0] wbRd,
    input logic [`RV_XLEN-1:0]      wbData
);

    // x0 never retires with a strobe
    wbRdNonZero: assert property (@(posedge clk) disable iff (!rstN)
        wbValid |-> (wbRd != '0))
        else $error("Write-back strobe raised for register x0");

    // Retired data is fully known
    wbDataKnown: assert property (@(posedge clk) disable iff (!rstN)
        wbValid |-> !$isunknown(wbData))
        else $error("Write-back data has unknown bits");

    // Sequential fetch, first cycle after reset skipped by the past term
    fetchStep: assert property (@(posedge clk) disable iff (!rstN)
        $past(rstN) |-> (imemAddr == $past(imemAddr) + `RV_PC_STEP))
        else $error("Fetch address did not advance by one instruction");

endmodule

bind rvPipe rvPipe_properties props (
    .clk      (clk),
    .rstN     (rstN),
    .imemAddr (imemAddr),
    .wbValid  (wbValid),
    .wbRd     (wbRd),
    .wbData   (wbData)
);

`default_nettype wire

//--- verif/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod  = 10,  // 20 ns clock
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // Reset released on a rising edge, like every other driven input
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/rvPipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_settings.svh"

module rvPipe import rvIsaPkg::*, rvPipePkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`RV_XLEN-1:0]      imemData,
    output logic [`RV_XLEN-1:0]      imemAddr,
    output logic                     wbValid,
    output logic [`RV_REG_IDX_W-1:0] wbRd,
    output logic [`RV_XLEN-1:0]      wbData
);

    // Fetch to decode
    instrWord            decInstr;
    logic [`RV_XLEN-1:0] decPc;

    // Register file read side
    logic [`RV_REG_IDX_W-1:0] rs1Idx;
    logic [`RV_REG_IDX_W-1:0] rs2Idx;
    logic [`RV_XLEN-1:0]      rs1Data;
    logic [`RV_XLEN-1:0]      rs2Data;

    // Decode to execute
    logic [`RV_XLEN-1:0]      exOpA;
    logic [`RV_XLEN-1:0]      exOpB;
    logic [`RV_XLEN-1:0]      exImm;
    logic [`RV_XLEN-1:0]      exPc;
    logic                     exSelA;
    logic                     exSelB;
    logic [aluOpW-1:0]        exAluOp;
    logic [`RV_REG_IDX_W-1:0] exRd;
    logic                     exWrEn;

    fetchStage fetch (
        .clk      (clk),
        .rstN     (rstN),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .decInstr (decInstr),
        .decPc    (decPc)
    );

    decodeStage decode (
        .clk      (clk),
        .rstN     (rstN),
        .decInstr (decInstr),
        .decPc    (decPc),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .rs1Idx   (rs1Idx),
        .rs2Idx   (rs2Idx),
        .exOpA    (exOpA),
        .exOpB    (exOpB),
        .exImm    (exImm),
        .exPc     (exPc),
        .exSelA   (exSelA),
        .exSelB   (exSelB),
        .exAluOp  (exAluOp),
        .exRd     (exRd),
        .exWrEn   (exWrEn)
    );

    // Written from the result register, so write-back and retire coincide
    regFile regs (
        .clk     (clk),
        .rs1Idx  (rs1Idx),
        .rs2Idx  (rs2Idx),
        .wrIdx   (wbRd),
        .wrEn    (wbValid),
        .wrData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    executeStage execute (
        .clk     (clk),
        .rstN    (rstN),
        .exOpA   (exOpA),
        .exOpB   (exOpB),
        .exImm   (exImm),
        .exPc    (exPc),
        .exSelA  (exSelA),
        .exSelB  (exSelB),
        .exAluOp (exAluOp),
        .exRd    (exRd),
        .exWrEn  (exWrEn),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_settings.svh"

module executeStage import rvPipePkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [`RV_XLEN-1:0]      exOpA,
    input  logic [`RV_XLEN-1:0]      exOpB,
    input  logic [`RV_XLEN-1:0]      exImm,
    input  logic [`RV_XLEN-1:0]      exPc,
    input  logic                     exSelA,
    input  logic                     exSelB,
    input  logic [aluOpW-1:0]        exAluOp,
    input  logic [`RV_REG_IDX_W-1:0] exRd,
    input  logic                     exWrEn,
    output logic                     wbValid,  // Also the register file write enable
    output logic [`RV_REG_IDX_W-1:0] wbRd,
    output logic [`RV_XLEN-1:0]      wbData
);

    logic [`RV_XLEN-1:0] aluA;
    logic [`RV_XLEN-1:0] aluB;
    logic [`RV_XLEN-1:0] aluResult;

    // Operand muxes
    assign aluA = (exSelA == selPc)  ? exPc  : exOpA;  // PC only for AUIPC
    assign aluB = (exSelB == selImm) ? exImm : exOpB;

    aluUnit alu (
        .opA    (aluA),
        .opB    (aluB),
        .aluOp  (exAluOp),
        .result (aluResult)
    );

    // Result register, drives the core outputs and the write port
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= exWrEn;  // Already cleared for x0 and unknown opcodes
        end
    end

    always_ff @(posedge clk) begin
        wbRd   <= exRd;
        wbData <= aluResult;
    end

endmodule

`default_nettype wire

//--- hdl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_settings.svh"

module aluUnit import rvPipePkg::*; (
    input  logic [`RV_XLEN-1:0] opA,
    input  logic [`RV_XLEN-1:0] opB,
    input  logic [aluOpW-1:0]   aluOp,
    output logic [`RV_XLEN-1:0] result
);

    logic [shamtW-1:0] shamt;
    logic              ltSigned;
    logic              ltUnsigned;

    assign shamt      = opB[shamtW-1:0];  // Upper bits of B are ignored
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = opA + opB;
            end
            aluSub: begin
                result = opA - opB;
            end
            aluSll: begin
                result = opA << shamt;
            end
            aluSlt: begin
                result = `RV_XLEN'(ltSigned);  // Zero-extended flag
            end
            aluSltu: begin
                result = `RV_XLEN'(ltUnsigned);
            end
            aluXor: begin
                result = opA ^ opB;
            end
            aluSrl: begin
                result = opA >> shamt;
            end
            aluSra: begin
                result = $unsigned($signed(opA) >>> shamt);  // Sign bit fills
            end
            aluOr: begin
                result = opA | opB;
            end
            aluAnd: begin
                result = opA & opB;
            end
            aluPassB: begin
                result = opB;  // LUI
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_settings.svh"

module decodeStage import rvIsaPkg::*, rvPipePkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  instrWord                 decInstr,
    input  logic [`RV_XLEN-1:0]      decPc,
    input  logic [`RV_XLEN-1:0]      rs1Data,
    input  logic [`RV_XLEN-1:0]      rs2Data,
    output logic [`RV_REG_IDX_W-1:0] rs1Idx,   // Register file read indices
    output logic [`RV_REG_IDX_W-1:0] rs2Idx,
    output logic [`RV_XLEN-1:0]      exOpA,    // rs1 value
    output logic [`RV_XLEN-1:0]      exOpB,    // rs2 value
    output logic [`RV_XLEN-1:0]      exImm,
    output logic [`RV_XLEN-1:0]      exPc,
    output logic                     exSelA,
    output logic                     exSelB,
    output logic [aluOpW-1:0]        exAluOp,
    output logic [`RV_REG_IDX_W-1:0] exRd,
    output logic                     exWrEn    // Valid bit of the decode/execute register
);

    logic [`RV_XLEN-1:0] iImm;
    logic [`RV_XLEN-1:0] uImm;
    logic [`RV_XLEN-1:0] imm;
    logic                selA;
    logic                selB;
    logic [aluOpW-1:0]   aluOp;
    logic                known;    // Opcode is one of the kept classes
    logic                isShift;  // funct3 where bit 30 matters
    logic                wrEn;

    assign rs1Idx = decInstr.rType.rs1;
    assign rs2Idx = decInstr.rType.rs2;

    assign iImm = {{(`RV_XLEN-12){decInstr.iType.imm12[11]}}, decInstr.iType.imm12};
    assign uImm = {decInstr.uType.imm20, 12'd0};  // Low 12 bits are zero

    // Bit 30 only selects sub/sra, it is ignored for the other funct3 values
    assign isShift = (decInstr.rType.funct3 == f3SrlSra);

    always_comb begin
        selA  = selRs1;
        selB  = selRs2;
        imm   = iImm;
        aluOp = aluAdd;
        known = 1'b0;
        case (decInstr.rType.opcode)
            opcodeOp: begin
                known = 1'b1;
                aluOp = {decInstr.rType.funct7[5] &&
                         (isShift || (decInstr.rType.funct3 == f3AddSub)),
                         decInstr.rType.funct3};
            end
            opcodeOpImm: begin
                known = 1'b1;
                selB  = selImm;
                aluOp = {isShift && decInstr.iType.imm12[10], decInstr.iType.funct3}; // srai
            end
            opcodeLui: begin
                known = 1'b1;
                selB  = selImm;
                imm   = uImm;
                aluOp = aluPassB;  // Result is the immediate itself
            end
            opcodeAuipc: begin
                known = 1'b1;
                selA  = selPc;
                selB  = selImm;
                imm   = uImm;
            end
            default: begin
                known = 1'b0;  // Retires as a bubble
            end
        endcase
    end

    assign wrEn = known && (decInstr.rType.rd != '0);  // Execute never tests rd again

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exWrEn <= 1'b0;
        end else begin
            exWrEn <= wrEn;
        end
    end

    // Payload of the decode/execute register
    always_ff @(posedge clk) begin
        exOpA   <= rs1Data;
        exOpB   <= rs2Data;
        exImm   <= imm;
        exPc    <= decPc;
        exSelA  <= selA;
        exSelB  <= selB;
        exAluOp <= aluOp;
        exRd    <= decInstr.rType.rd;
    end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_settings.svh"

module regFile (
    input  logic                     clk,
    input  logic [`RV_REG_IDX_W-1:0] rs1Idx,
    input  logic [`RV_REG_IDX_W-1:0] rs2Idx,
    input  logic [`RV_REG_IDX_W-1:0] wrIdx,
    input  logic                     wrEn,
    input  logic [`RV_XLEN-1:0]      wrData,
    output logic [`RV_XLEN-1:0]      rs1Data,
    output logic [`RV_XLEN-1:0]      rs2Data
);

    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];  // No storage behind x0

    // Read priority is x0, then the write in flight, then storage
    function automatic logic [`RV_XLEN-1:0] readPort(input logic [`RV_REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (wrEn && (idx == wrIdx)) begin
            return wrData;  // Write-first bypass
        end else begin
            return regs[idx];
        end
    endfunction

    always_ff @(posedge clk) begin
        if (wrEn && (wrIdx != '0)) begin
            regs[wrIdx] <= wrData;  // x0 writes are dropped
        end
    end

    // Also follows the write port and the storage, not only the indices
    always_comb begin
        rs1Data = readPort(rs1Idx);
        rs2Data = readPort(rs2Idx);
    end

endmodule

`default_nettype wire

//--- hdl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_settings.svh"

module fetchStage import rvIsaPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  logic [`RV_XLEN-1:0] imemData,  // Valid in the same cycle as imemAddr
    output logic [`RV_XLEN-1:0] imemAddr,
    output instrWord            decInstr,  // Fetch/decode instruction register
    output logic [`RV_XLEN-1:0] decPc      // PC of decInstr
);

    // addi x0, x0, 0
    localparam instrWord nopInstr = {12'd0, 5'd0, f3AddSub, 5'd0, opcodeOpImm};

    logic [`RV_XLEN-1:0] pc;

    assign imemAddr = pc;  // Memory is addressed straight from the PC

    // Program counter, no redirects in this core
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc + `RV_PC_STEP;  // Sequential fetch only
        end
    end

    // Instruction register resets to a NOP so decode retires nothing
    always_ff @(posedge clk) begin
        if (!rstN) begin
            decInstr <= nopInstr;
        end else begin
            decInstr <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        decPc <= pc;  // Follows decInstr, only AUIPC reads it
    end

endmodule

`default_nettype wire

//--- hdl/rvPipePkg.sv
`default_nettype none
`include "rvPipe_settings.svh"

package rvPipePkg;

    // Operand A and B selects
    localparam logic selRs1 = 1'b0;
    localparam logic selPc  = 1'b1; // AUIPC
    localparam logic selRs2 = 1'b0;
    localparam logic selImm = 1'b1;

    // ALU op is {bit30, funct3}, with one spare code for LUI
    localparam int aluOpW = 4;
    localparam int shamtW = $clog2(`RV_XLEN); // Shift amount from low bits of B

    localparam logic [aluOpW-1:0] aluAdd   = 4'b0000;
    localparam logic [aluOpW-1:0] aluSub   = 4'b1000;
    localparam logic [aluOpW-1:0] aluSll   = 4'b0001;
    localparam logic [aluOpW-1:0] aluSlt   = 4'b0010;
    localparam logic [aluOpW-1:0] aluSltu  = 4'b0011;
    localparam logic [aluOpW-1:0] aluXor   = 4'b0100;
    localparam logic [aluOpW-1:0] aluSrl   = 4'b0101;
    localparam logic [aluOpW-1:0] aluSra   = 4'b1101;
    localparam logic [aluOpW-1:0] aluOr    = 4'b0110;
    localparam logic [aluOpW-1:0] aluAnd   = 4'b0111;
    localparam logic [aluOpW-1:0] aluPassB = 4'b1111; // Never produced by bit30 decode

endpackage

`default_nettype wire

//--- hdl/rvIsaPkg.sv
`default_nettype none
`include "rvPipe_settings.svh"

package rvIsaPkg;

    // Major opcodes kept by the core
    localparam logic [6:0] opcodeOp    = 7'b0110011; // R-type ALU
    localparam logic [6:0] opcodeOpImm = 7'b0010011; // I-type ALU
    localparam logic [6:0] opcodeLui   = 7'b0110111;
    localparam logic [6:0] opcodeAuipc = 7'b0010111;

    // funct3 of the integer ALU group
    localparam logic [2:0] f3AddSub = 3'b000; // Bit 30 picks sub on R-type
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101; // Bit 30 picks sra
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0]               funct7;  // Bit 5 is instruction bit 30
            logic [`RV_REG_IDX_W-1:0] rs2;
            logic [`RV_REG_IDX_W-1:0] rs1;
            logic [2:0]               funct3;
            logic [`RV_REG_IDX_W-1:0] rd;
            logic [6:0]               opcode;
        } rType;
        struct packed {
            logic [11:0]              imm12;   // Sign bit at the top
            logic [`RV_REG_IDX_W-1:0] rs1;
            logic [2:0]               funct3;
            logic [`RV_REG_IDX_W-1:0] rd;
            logic [6:0]               opcode;
        } iType;
        struct packed {
            logic [19:0]              imm20;   // Upper 20 bits of the result
            logic [`RV_REG_IDX_W-1:0] rd;
            logic [6:0]               opcode;
        } uType;
    } instrWord;

endpackage

`default_nettype wire

//--- hdl/rvPipe_settings.svh
`ifndef RV_PIPE_SETTINGS_SVH
`define RV_PIPE_SETTINGS_SVH

// Datapath and address width
`define RV_XLEN 32

// Architectural register file
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// Fetch sequencing
`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP 32'd4

`endif
